/* sim.f */
+incdir+sim
source/dft_pkg.sv
source/twiddle_table.sv
source/bin_sequencer.sv
source/complex_macc.sv
source/output_cast.sv
source/dft_bin_top.sv
sim/tb_dft_bin.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then scan the log for the fail line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dft_bin -f sim.f -o tb_dft_bin \
    > build.log 2>&1 \
    && ./obj_dir/tb_dft_bin > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

/* sim/tb_dft_model.svh */
`ifndef TB_DFT_MODEL_SVH
`define TB_DFT_MODEL_SVH

// expected results, and the cycle of each frame's last sample
bin_result_t   exp_q [$];
int            cyc_q [$];
twiddle_pair_t shadow_tw [MAX_LEN];

localparam longint DOUT_MAX = (64'sd1 <<< (DOUT_W - 1)) - 64'sd1;
localparam longint DOUT_MIN = -DOUT_MAX - 64'sd1;

// floor by the cast shift, then clamp to the result range
function automatic dout_t floor_clamp(input longint v, inout logic clamped);
    longint f;
    f = v >>> CAST_SHIFT;
    if (f > DOUT_MAX) begin
        clamped = 1'b1;
        f       = DOUT_MAX;
    end else if (f < DOUT_MIN) begin
        clamped = 1'b1;
        f       = DOUT_MIN;
    end
    return dout_t'(f);
endfunction

function automatic void expect_frame(input lane_samples_t s [MAX_LEN], input int len,
                                     input twiddle_pair_t tw [MAX_LEN], input int last_cycle);
    bin_result_t exp_r;
    logic        ovf;
    longint      sum_re;
    longint      sum_im;
    longint      ar;
    longint      ai;
    longint      br;
    longint      bi;
    exp_r = '0;
    ovf   = 1'b0;
    for (int l = 0; l < N_LANES; l++) begin
        sum_re = 0;
        sum_im = 0;
        for (int n = 0; n < len; n++) begin
            ar = longint'($signed(s[n].lane[l].re));
            ai = longint'($signed(s[n].lane[l].im));
            br = longint'($signed(tw[n].re));
            bi = longint'($signed(tw[n].im));
            sum_re += ar * br - ai * bi;
            sum_im += ar * bi + ai * br;
        end
        exp_r.lane[l].re = floor_clamp(sum_re, ovf);
        exp_r.lane[l].im = floor_clamp(sum_im, ovf);
    end
    exp_r.valid    = 1'b1;
    exp_r.overflow = ovf;
    exp_q.push_back(exp_r);
    cyc_q.push_back(last_cycle);
endfunction

`endif

/* sim/tb_dft_bin.sv */
`timescale 1ns/1ps

module tb_dft_bin;
    import dft_pkg::*;

    logic          clk = 1'b0;
    logic          rst;
    lane_samples_t din;
    logic          din_valid;
    addr_t         last_index;
    logic          twiddle_we;
    addr_t         twiddle_addr;
    twiddle_pair_t twiddle_data;
    bin_result_t   result;
    logic          cast_warning;

    integer        seed;
    int            cycle = 0;
    int            errors = 0;
    int            frames_checked = 0;
    int            samples_sent = 0;
    lane_samples_t frame_buf [MAX_LEN];

    `include "tb_dft_model.svh"

    dft_bin_top dft_bin_top_i (
        .clk          (clk),
        .rst          (rst),
        .din          (din),
        .din_valid    (din_valid),
        .last_index   (last_index),
        .twiddle_we   (twiddle_we),
        .twiddle_addr (twiddle_addr),
        .twiddle_data (twiddle_data),
        .result       (result),
        .cast_warning (cast_warning)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // kind 0 random, 1 cosine/sine for bin 5, 2 full scale
    task automatic load_table(input int kind);
        real           angle;
        twiddle_pair_t w;
        for (int n = 0; n < MAX_LEN; n++) begin
            angle = 2.0 * 3.14159265358979 * 5 * n / MAX_LEN;
            if (kind == 0) begin
                w = twiddle_pair_t'($random(seed));
            end else if (kind == 1) begin
                w.re = twiddle_t'($rtoi(16383.0 * $cos(angle)));
                w.im = twiddle_t'($rtoi(-16383.0 * $sin(angle)));
            end else begin
                w = {16'sh7fff, 16'sh8000};
            end
            @(negedge clk);
            din_valid    = 1'b0;
            twiddle_we   = 1'b1;
            twiddle_addr = addr_t'(n);
            twiddle_data = w;
            shadow_tw[n] = w;
        end
        @(negedge clk);
        twiddle_we = 1'b0;
    endtask

    // shift scales random samples down, full_scale overrides them
    task automatic fill_frame(input int len, input int shift, input bit full_scale);
        for (int j = 0; j < len; j++) begin
            for (int l = 0; l < N_LANES; l++) begin
                frame_buf[j].lane[l].re = sample_t'($random(seed)) >>> shift;
                frame_buf[j].lane[l].im = sample_t'($random(seed)) >>> shift;
                if (full_scale) begin
                    frame_buf[j].lane[l] = {16'sh7fff, 16'sh8000};
                end
            end
        end
    endtask

    task automatic send_frame(input int len, input int max_gap, input int mid_index);
        for (int j = 0; j < len; j++) begin
            repeat ((max_gap > 0) ? rand_below(max_gap + 1) : 0) begin
                @(negedge clk);
                din_valid = 1'b0;
            end
            @(negedge clk);
            din_valid  = 1'b1;
            din        = frame_buf[j];
            last_index = (j > 0 && mid_index >= 0) ? addr_t'(mid_index) : addr_t'(len - 1);
        end
        samples_sent += len;
        expect_frame(frame_buf, len, shadow_tw, cycle);
    endtask

    task automatic wait_drain();
        @(negedge clk);
        din_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic apply_reset();
        seq_state_t st;
        @(negedge clk);
        rst       = 1'b1;
        din_valid = 1'b0;
        repeat (16) @(negedge clk);
        st = dft_bin_top_i.bin_sequencer_i.state;
        if (st != idle || dft_bin_top_i.bin_sequencer_i.pos != '0) begin
            errors++;
            $display("** Error @%0t: sequencer in state %s after reset", $time, st.name());
        end
        // frames cut by the reset never finish
        exp_q.delete();
        cyc_q.delete();
        rst = 1'b0;
    endtask

    always @(negedge clk) begin
        bin_result_t exp_r;
        int          exp_cycle;
        if (!rst && result.valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("** Error @%0t: unexpected output, no frame pending", $time);
            end else begin
                exp_r     = exp_q.pop_front();
                exp_cycle = cyc_q.pop_front();
                frames_checked++;
                for (int l = 0; l < N_LANES; l++) begin
                    if (result.lane[l] !== exp_r.lane[l]) begin
                        errors++;
                        $display("** Error @%0t: lane %0d got %0d/%0d expected %0d/%0d",
                                 $time, l, result.lane[l].re, result.lane[l].im,
                                 exp_r.lane[l].re, exp_r.lane[l].im);
                    end
                end
                if (result.overflow !== exp_r.overflow || cast_warning !== exp_r.overflow) begin
                    errors++;
                    $display("** Error @%0t: overflow %b warning %b expected %b",
                             $time, result.overflow, cast_warning, exp_r.overflow);
                end
                if (cycle - exp_cycle != 5) begin
                    errors++;
                    $display("** Error @%0t: result %0d cycles after last sample, expected 5",
                             $time, cycle - exp_cycle);
                end
            end
        end else if (!rst && cast_warning !== 1'b0) begin
            errors++;
            $display("** Error @%0t: cast_warning high without result.valid", $time);
        end
    end

    initial begin
        wait (cycle > 4 * samples_sent + 2000);
        $display("watchdog: run did not finish within %0d cycles", cycle);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int len;
        seed         = 32'hf4a9_8a03;
        rst          = 1'b1;
        din          = '0;
        din_valid    = 1'b0;
        last_index   = '0;
        twiddle_we   = 1'b0;
        twiddle_addr = '0;
        twiddle_data = '0;
        apply_reset();

        load_table(0);
        fill_frame(8, 0, 0);
        send_frame(8, 0, -1);
        wait_drain();

        // every third frame starts right after the previous one
        for (int f = 0; f < 20; f++) begin
            len = 1 + rand_below(16);
            fill_frame(len, 0, 0);
            send_frame(len, (f % 3 == 0) ? 0 : 3, -1);
        end
        wait_drain();

        // last_index moves between frames and inside them
        fill_frame(1, 0, 0);
        send_frame(1, 1, -1);
        fill_frame(4, 0, 0);
        send_frame(4, 1, 127);
        fill_frame(128, 0, 0);
        send_frame(128, 0, 3);
        fill_frame(4, 0, 0);
        send_frame(4, 2, 0);
        wait_drain();

        load_table(1);
        fill_frame(128, 0, 0);
        send_frame(128, 1, -1);
        fill_frame(32, 0, 0);
        send_frame(32, 0, -1);
        wait_drain();

        // saturating frame, then a quiet one
        load_table(2);
        fill_frame(128, 0, 1);
        send_frame(128, 0, -1);
        fill_frame(8, 7, 0);
        send_frame(8, 1, -1);
        wait_drain();

        fill_frame(10, 0, 0);
        for (int j = 0; j < 10; j++) begin
            @(negedge clk);
            din_valid  = 1'b1;
            din        = frame_buf[j];
            last_index = addr_t'(63);
        end
        samples_sent += 10;
        apply_reset();
        fill_frame(16, 0, 0);
        send_frame(16, 2, -1);
        wait_drain();
        repeat (10) @(negedge clk);

        if (exp_q.size() != 0) begin
            $display("%0d frames never produced a result", exp_q.size());
        end
        errors += exp_q.size();
        $display("frames checked: %0d, errors: %0d", frames_checked, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* source/dft_bin_top.sv */
`timescale 1ns/1ps

module dft_bin_top (
    input  logic                   clk,
    input  logic                   rst,
    input  dft_pkg::lane_samples_t din,
    input  logic                   din_valid,
    input  dft_pkg::addr_t         last_index,
    input  logic                   twiddle_we,
    input  dft_pkg::addr_t         twiddle_addr,
    input  dft_pkg::twiddle_pair_t twiddle_data,
    output dft_pkg::bin_result_t   result,
    output logic                   cast_warning
);
    import dft_pkg::*;

    addr_t         rd_addr;
    twiddle_pair_t rd_data;
    mac_in_t       mac_in;
    lane_sums_t    sums;

    twiddle_table twiddle_table_i (
        .clk     (clk),
        .rst     (rst),
        .we      (twiddle_we),
        .wr_addr (twiddle_addr),
        .wr_data (twiddle_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // decode
    bin_sequencer bin_sequencer_i (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_valid  (din_valid),
        .last_index (last_index),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .mac_in     (mac_in)
    );

    // execute
    complex_macc complex_macc_i (
        .clk    (clk),
        .rst    (rst),
        .mac_in (mac_in),
        .sums   (sums)
    );

    // result
    output_cast output_cast_i (
        .clk    (clk),
        .rst    (rst),
        .sums   (sums),
        .result (result)
    );

    assign cast_warning = result.valid & result.overflow;

endmodule

/* source/output_cast.sv */
`timescale 1ns/1ps

module output_cast (
    input  logic                 clk,
    input  logic                 rst,
    input  dft_pkg::lane_sums_t  sums,
    output dft_pkg::bin_result_t result
);
    import dft_pkg::*;

    typedef struct packed {
        logic  clamp;
        dout_t value;
    } cast_t;

    cast_t cast_re [N_LANES];
    cast_t cast_im [N_LANES];
    logic  any_clamp;

    // floor by arithmetic shift, then clamp to the signed result range
    function automatic cast_t floor_sat(input acc_t x);
        acc_t  shifted;
        cast_t c;
        shifted = x >>> CAST_SHIFT;
        if (shifted[ACC_W-1:DOUT_W-1] == {(ACC_W-DOUT_W+1){shifted[ACC_W-1]}}) begin
            c.value = shifted[DOUT_W-1:0];
            c.clamp = 1'b0;
        end else begin
            c.value = shifted[ACC_W-1] ? {1'b1, {(DOUT_W-1){1'b0}}}
                                       : {1'b0, {(DOUT_W-1){1'b1}}};
            c.clamp = 1'b1;
        end
        return c;
    endfunction

    always_comb begin
        any_clamp = 1'b0;
        for (int i = 0; i < N_LANES; i++) begin
            cast_re[i] = floor_sat(sums.lane[i].re);
            cast_im[i] = floor_sat(sums.lane[i].im);
            any_clamp  = any_clamp | cast_re[i].clamp | cast_im[i].clamp;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N_LANES; i++) begin
            result.lane[i].re <= cast_re[i].value;
            result.lane[i].im <= cast_im[i].value;
        end
        if (rst) begin
            result.valid    <= 1'b0;
            result.overflow <= 1'b0;
        end else begin
            result.valid    <= sums.valid;
            result.overflow <= sums.valid && any_clamp;
        end
    end

    a_overflow_has_valid: assert property (
        @(posedge clk) disable iff (rst)
        result.overflow |-> result.valid
    );

endmodule

/* source/complex_macc.sv */
`timescale 1ns/1ps

module complex_macc (
    input  logic                clk,
    input  logic                rst,
    input  dft_pkg::mac_in_t    mac_in,
    output dft_pkg::lane_sums_t sums
);
    import dft_pkg::*;

    sample_t                  s_re [N_LANES];
    sample_t                  s_im [N_LANES];
    twiddle_t                 tw_re;
    twiddle_t                 tw_im;
    logic signed [PROD_W-1:0] prod_re [N_LANES];
    logic signed [PROD_W-1:0] prod_im [N_LANES];
    logic                     prod_valid;
    logic                     prod_last;
    logic                     first_q;
    acc_t                     acc_re [N_LANES];
    acc_t                     acc_im [N_LANES];
    logic                     sum_valid;

    assign tw_re = mac_in.twiddle.re;
    assign tw_im = mac_in.twiddle.im;

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            s_re[i] = mac_in.samples.lane[i].re;
            s_im[i] = mac_in.samples.lane[i].im;
        end
    end

    // full precision product, point at bit 29
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_LANES; i++) begin
            prod_re[i] <= s_re[i] * tw_re - s_im[i] * tw_im;
            prod_im[i] <= s_re[i] * tw_im + s_im[i] * tw_re;
        end
        if (rst) begin
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= mac_in.valid;
            prod_last  <= mac_in.last;
        end
    end

    // first product of a frame loads, the rest add
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            for (int i = 0; i < N_LANES; i++) begin
                acc_re[i] <= first_q ? acc_t'(prod_re[i]) : acc_re[i] + prod_re[i];
                acc_im[i] <= first_q ? acc_t'(prod_im[i]) : acc_im[i] + prod_im[i];
            end
        end
        if (rst) begin
            first_q   <= 1'b1;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= prod_valid && prod_last;
            if (prod_valid) begin
                first_q <= prod_last;
            end
        end
    end

    always_comb begin
        sums.valid = sum_valid;
        for (int i = 0; i < N_LANES; i++) begin
            sums.lane[i].re = acc_re[i];
            sums.lane[i].im = acc_im[i];
        end
    end

    // back to back sums only when the second frame held a single sample
    a_one_sum_per_frame: assert property (
        @(posedge clk) disable iff (rst)
        sum_valid |=> !sum_valid || $past(mac_in.valid && mac_in.last, 2)
    );

endmodule

/* source/bin_sequencer.sv */
`timescale 1ns/1ps

module bin_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  dft_pkg::lane_samples_t din,
    input  logic                   din_valid,
    input  dft_pkg::addr_t         last_index,
    output dft_pkg::addr_t         rd_addr,
    input  dft_pkg::twiddle_pair_t rd_data,
    output dft_pkg::mac_in_t       mac_in
);
    import dft_pkg::*;

    seq_state_t    state;
    addr_t         pos;
    addr_t         len_q;
    addr_t         frame_last;
    logic          at_last;
    lane_samples_t din_q;
    logic          valid_q;
    logic          last_q;

    // live index only on the first sample, latched copy after that
    assign frame_last = (state == idle) ? last_index : len_q;
    assign at_last    = (pos == frame_last);
    assign rd_addr    = pos;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            pos   <= '0;
            len_q <= '0;
        end else if (din_valid) begin
            if (state == idle) begin
                len_q <= last_index;
            end
            if (at_last) begin
                pos   <= '0;
                state <= idle;
            end else begin
                pos   <= pos + 1'b1;
                state <= in_frame;
            end
        end
    end

    // two stages so samples meet the registered twiddle
    always_ff @(posedge clk) begin
        din_q          <= din;
        mac_in.samples <= din_q;
        mac_in.twiddle <= rd_data;
        if (rst) begin
            valid_q      <= 1'b0;
            last_q       <= 1'b0;
            mac_in.valid <= 1'b0;
            mac_in.last  <= 1'b0;
        end else begin
            valid_q      <= din_valid;
            last_q       <= din_valid && at_last;
            mac_in.valid <= valid_q;
            mac_in.last  <= last_q;
        end
    end

    a_last_has_valid: assert property (
        @(posedge clk) disable iff (rst)
        mac_in.last |-> mac_in.valid
    );

endmodule

/* source/twiddle_table.sv */
`timescale 1ns/1ps

module twiddle_table (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we,
    input  dft_pkg::addr_t         wr_addr,
    input  dft_pkg::twiddle_pair_t wr_data,
    input  dft_pkg::addr_t         rd_addr,
    output dft_pkg::twiddle_pair_t rd_data
);
    import dft_pkg::*;

    twiddle_pair_t mem [MAX_LEN];

    // write side, loaded between frames
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, one cycle behind the address
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* source/dft_pkg.sv */
package dft_pkg;

    localparam int N_LANES    = 2;
    localparam int MAX_LEN    = 128;
    localparam int ADDR_W     = 7;

    // Q1.15 samples, Q2.14 twiddles
    localparam int SAMPLE_W   = 16;
    localparam int TWIDDLE_W  = 16;
    localparam int PROD_W     = 33;
    localparam int ACC_W      = 40;

    // result keeps 15 fractional bits
    localparam int DOUT_W     = 24;
    localparam int CAST_SHIFT = 14;

    typedef logic signed [SAMPLE_W-1:0]  sample_t;
    typedef logic signed [TWIDDLE_W-1:0] twiddle_t;
    typedef logic        [ADDR_W-1:0]    addr_t;
    typedef logic signed [ACC_W-1:0]     acc_t;
    typedef logic signed [DOUT_W-1:0]    dout_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    // one table word, 32 bits
    typedef struct packed {
        twiddle_t re;
        twiddle_t im;
    } twiddle_pair_t;

    typedef struct packed {
        cplx_sample_t [N_LANES-1:0] lane;
    } lane_samples_t;

    typedef struct packed {
        logic          valid;
        logic          last;
        lane_samples_t samples;
        twiddle_pair_t twiddle;
    } mac_in_t;

    typedef struct packed {
        acc_t re;
        acc_t im;
    } acc_pair_t;

    typedef struct packed {
        logic                    valid;
        acc_pair_t [N_LANES-1:0] lane;
    } lane_sums_t;

    typedef struct packed {
        dout_t re;
        dout_t im;
    } dout_pair_t;

    typedef struct packed {
        logic                     valid;
        dout_pair_t [N_LANES-1:0] lane;
        logic                     overflow;
    } bin_result_t;

    typedef enum logic {
        idle,
        in_frame
    } seq_state_t;

endpackage
